//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_conv_engine
FILELIST  := build.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+design
design/engine_pkg.sv
design/atom_loader.sv
design/mac_lane.sv
design/channel_sum.sv
design/engine_ctrl.sv
design/conv_engine.sv
verification/engine_properties.sv
verification/tb_conv_engine.sv

//--- design/atom_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "engine_macros.svh"

module atom_loader (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               i_busy,
	input  wire engine_pkg::cmd_t   i_cmd,
	input  wire logic               i_data_we,
	input  wire engine_pkg::word_t  i_data,
	input  wire logic               i_weight_we,
	input  wire engine_pkg::word_t  i_weight,
	output engine_pkg::atom_t       o_atom,
	output logic                    o_atom_valid
);

	localparam int BL    = `ENGINE_BURST_LEN;
	localparam int CNT_W = $clog2(BL + 1);   // Counts 0 to BL inclusive

	engine_pkg::word_t [BL-1:0] data_buf;     // Deserializer for the feature stream
	engine_pkg::word_t [BL-1:0] weight_buf;   // Deserializer for the weight stream
	logic [CNT_W-1:0]           data_cnt;
	logic [CNT_W-1:0]           weight_cnt;
	logic [`ENGINE_KSIZE_W-1:0] atom_cnt;     // Atoms issued for the current point
	logic                       data_take;
	logic                       weight_take;
	logic                       issue;
	logic                       last_atom;

	// Strobes only count while a layer runs
	assign data_take   = i_busy && i_data_we;
	assign weight_take = i_busy && i_weight_we;

	// Both buffers hold a whole atom
	assign issue = i_busy && (data_cnt == CNT_W'(BL)) && (weight_cnt == CNT_W'(BL));

	assign last_atom = atom_cnt == i_cmd.kernel_size - 1'b1;

	// New word enters at the top, so after BL shifts word k sits in element k
	always_ff @(posedge clk) begin
		if (data_take)
			data_buf <= {i_data, data_buf[BL-1:1]};
		if (weight_take)
			weight_buf <= {i_weight, weight_buf[BL-1:1]};
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			data_cnt     <= '0;
			weight_cnt   <= '0;
			atom_cnt     <= '0;
			o_atom_valid <= 1'b0;
		end else if (!i_busy) begin
			data_cnt     <= '0;   // Idle engine drops partial atoms
			weight_cnt   <= '0;
			atom_cnt     <= '0;
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= issue;
			if (issue) begin
				// Buffers empty out as the atom goes
				data_cnt   <= CNT_W'(data_take);
				weight_cnt <= CNT_W'(weight_take);
				atom_cnt   <= last_atom ? '0 : atom_cnt + 1'b1;
			end else begin
				data_cnt   <= data_cnt + CNT_W'(data_take);
				weight_cnt <= weight_cnt + CNT_W'(weight_take);
			end
		end
	end

	// Atom register loaded only on issue
	always_ff @(posedge clk) begin
		if (issue) begin
			o_atom.data   <= data_buf;
			o_atom.weight <= weight_buf;
			o_atom.last   <= last_atom;   // Closes the point in every lane
		end
	end

endmodule

`default_nettype wire

//--- design/channel_sum.sv
`timescale 1ns/1ps
`default_nettype none
`include "engine_macros.svh"

module channel_sum (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire engine_pkg::lane_sums_t i_sums,
	input  wire logic                   i_sums_valid,
	output engine_pkg::word_t           o_result,
	output logic                        o_result_valid
);

	localparam int BL    = `ENGINE_BURST_LEN;
	localparam int CNT_W = $clog2(BL + 1);

	engine_pkg::lane_sums_t sums_sh;   // Remaining lanes with the next one in element 0
	engine_pkg::word_t      acc;
	logic [CNT_W-1:0]       lane_cnt;  // Lanes taken so far and zero when idle
	logic                   final_add;

	// Last lane goes in this cycle
	assign final_add = (lane_cnt == CNT_W'(BL - 1)) && !i_sums_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane_cnt       <= '0;
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= final_add;
			if (i_sums_valid)
				lane_cnt <= CNT_W'(1);           // Lane 0 is taken on the latch edge
			else if (final_add)
				lane_cnt <= '0;
			else if (lane_cnt != '0)
				lane_cnt <= lane_cnt + 1'b1;
		end
	end

	// Shift register and running total
	always_ff @(posedge clk) begin
		if (i_sums_valid) begin
			acc     <= i_sums[0];
			sums_sh <= {engine_pkg::word_t'(0), i_sums[BL-1:1]};
		end else if (lane_cnt != '0) begin
			acc     <= acc + sums_sh[0];    // One lane per cycle
			sums_sh <= {engine_pkg::word_t'(0), sums_sh[BL-1:1]};
		end
		if (final_add)
			o_result <= acc + sums_sh[0];   // Total over all channels
	end

endmodule

`default_nettype wire

//--- design/conv_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "engine_macros.svh"

module conv_engine (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              i_start,
	input  wire engine_pkg::cmd_t  i_cmd,
	input  wire logic              i_data_we,
	input  wire engine_pkg::word_t i_data,
	input  wire logic              i_weight_we,
	input  wire engine_pkg::word_t i_weight,
	output engine_pkg::word_t      o_result,
	output logic                   o_result_valid,
	output logic                   o_ready
);

	engine_pkg::cmd_t       cmd;         // Latched layer command
	logic                   busy;
	engine_pkg::atom_t      atom;
	logic                   atom_valid;
	engine_pkg::lane_sums_t lane_sums;
	logic                   sums_valid;

	engine_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.i_start        (i_start),
		.i_cmd          (i_cmd),
		.i_result_valid (o_result_valid),   // Counts finished points
		.o_cmd          (cmd),
		.o_busy         (busy),
		.o_ready        (o_ready)
	);

	atom_loader u_loader (
		.clk          (clk),
		.rst          (rst),
		.i_busy       (busy),
		.i_cmd        (cmd),
		.i_data_we    (i_data_we),
		.i_data       (i_data),
		.i_weight_we  (i_weight_we),
		.i_weight     (i_weight),
		.o_atom       (atom),
		.o_atom_valid (atom_valid)
	);

	// One MAC lane per channel of the atom
	for (genvar g = 0; g < `ENGINE_BURST_LEN; g++) begin : g_lane
		logic lane_valid;
		mac_lane u_lane (
			.clk          (clk),
			.rst          (rst),
			.i_atom_valid (atom_valid),
			.i_last       (atom.last),
			.i_data       (atom.data[g]),
			.i_weight     (atom.weight[g]),
			.o_sum        (lane_sums[g]),
			.o_sum_valid  (lane_valid)
		);
	end

	assign sums_valid = g_lane[0].lane_valid;   // Lanes run in lockstep

	channel_sum u_sum (
		.clk            (clk),
		.rst            (rst),
		.i_sums         (lane_sums),
		.i_sums_valid   (sums_valid),
		.o_result       (o_result),
		.o_result_valid (o_result_valid)
	);

endmodule

`default_nettype wire

//--- design/engine_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "engine_macros.svh"

module engine_ctrl (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             i_start,
	input  wire engine_pkg::cmd_t i_cmd,
	input  wire logic             i_result_valid,
	output engine_pkg::cmd_t      o_cmd,
	output logic                  o_busy,
	output logic                  o_ready
);

	engine_pkg::engine_state_t   state;
	logic [`ENGINE_POINTS_W-1:0] done_cnt;   // Results seen in this layer
	logic                        last_result;

	assign last_result = i_result_valid && (done_cnt == o_cmd.points - 1'b1);

	assign o_busy = state == engine_pkg::ST_BUSY;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= engine_pkg::ST_IDLE;
			o_cmd    <= '0;
			done_cnt <= '0;
			o_ready  <= 1'b0;
		end else begin
			case (state)
				engine_pkg::ST_IDLE: begin
					if (i_start) begin   // Start only counts here
						o_cmd    <= i_cmd;
						done_cnt <= '0;
						o_ready  <= 1'b0;
						state    <= engine_pkg::ST_BUSY;
					end
				end
				engine_pkg::ST_BUSY: begin
					if (last_result) begin
						o_ready <= 1'b1;   // Held until the next accepted start
						state   <= engine_pkg::ST_IDLE;
					end
					if (i_result_valid)
						done_cnt <= done_cnt + 1'b1;
				end
				default: state <= engine_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/engine_macros.svh
`ifndef ENGINE_MACROS_SVH
`define ENGINE_MACROS_SVH

// Channels per atom and number of MAC lanes
`define ENGINE_BURST_LEN 4

// Data, weight and sum word width
`define ENGINE_WORD_W 16

// Atoms per output point from 1 to 9
`define ENGINE_KSIZE_W 4

// Output points per layer from 1 to 255
`define ENGINE_POINTS_W 8

`endif

//--- design/engine_pkg.sv
`default_nettype none
`include "engine_macros.svh"

package engine_pkg;

	typedef logic [`ENGINE_WORD_W-1:0] word_t;   // One data, weight or sum word

	// One channel-parallel slice as fed to the lanes
	typedef struct packed {
		word_t [`ENGINE_BURST_LEN-1:0] data;     // Channel k in element k
		word_t [`ENGINE_BURST_LEN-1:0] weight;
		logic                          last;     // Final atom of the point
	} atom_t;

	typedef word_t [`ENGINE_BURST_LEN-1:0] lane_sums_t;   // One sum per lane

	// Layer command latched on start
	typedef struct packed {
		logic [`ENGINE_KSIZE_W-1:0]  kernel_size;   // Atoms per point
		logic [`ENGINE_POINTS_W-1:0] points;        // Points in the layer
	} cmd_t;

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} engine_state_t;

endpackage

`default_nettype wire

//--- design/mac_lane.sv
`timescale 1ns/1ps
`default_nettype none

module mac_lane (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               i_atom_valid,
	input  wire logic               i_last,
	input  wire engine_pkg::word_t  i_data,
	input  wire engine_pkg::word_t  i_weight,
	output engine_pkg::word_t       o_sum,
	output logic                    o_sum_valid
);

	engine_pkg::word_t prod;       // Low half of the product
	engine_pkg::word_t acc;        // Running sum over the point's atoms
	engine_pkg::word_t acc_next;

	assign prod     = i_data * i_weight;   // 16-bit context keeps the low bits
	assign acc_next = acc + prod;          // Wraps mod 2^16

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc         <= '0;
			o_sum_valid <= 1'b0;
		end else begin
			o_sum_valid <= i_atom_valid && i_last;
			if (i_atom_valid)
				acc <= i_last ? '0 : acc_next;   // Next point starts from zero
		end
	end

	// Final sum of the point held until the next one
	always_ff @(posedge clk) begin
		if (i_atom_valid && i_last)
			o_sum <= acc_next;
	end

endmodule

`default_nettype wire

//--- verification/engine_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "engine_macros.svh"

module engine_properties (
	input wire logic clk,
	input wire logic rst,
	input wire logic i_busy,
	input wire logic i_data_we,
	input wire logic i_weight_we,
	input wire logic i_result_valid,
	input wire logic i_ready
);

	localparam int BL = `ENGINE_BURST_LEN;

	int   data_cnt;     // Words waiting in the loader's data buffer
	int   weight_cnt;
	logic issue;        // Both buffers full so the atom leaves this cycle

	assign issue = i_busy && (data_cnt == BL) && (weight_cnt == BL);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			data_cnt   <= 0;
			weight_cnt <= 0;
		end else if (!i_busy) begin
			data_cnt   <= 0;   // Idle engine ignores strobes
			weight_cnt <= 0;
		end else begin
			data_cnt   <= (issue ? 0 : data_cnt) + (i_data_we ? 1 : 0);
			weight_cnt <= (issue ? 0 : weight_cnt) + (i_weight_we ? 1 : 0);
		end
	end

	// A full buffer may only take a word in the cycle its atom is issued
	a_data_room: assert property (@(posedge clk) disable iff (rst)
		i_busy && i_data_we && (data_cnt == BL) |-> weight_cnt == BL)
		else $error("Data word sent while the data buffer is full");

	a_weight_room: assert property (@(posedge clk) disable iff (rst)
		i_busy && i_weight_we && (weight_cnt == BL) |-> data_cnt == BL)
		else $error("Weight word sent while the weight buffer is full");

	a_result_pulse: assert property (@(posedge clk) disable iff (rst)
		i_result_valid |=> !i_result_valid)
		else $error("Result strobe held for more than one cycle");

	a_ready_idle: assert property (@(posedge clk) disable iff (rst)
		i_busy |-> !i_ready)
		else $error("Ready high while the engine is busy");

endmodule

bind conv_engine engine_properties u_props (
	.clk            (clk),
	.rst            (rst),
	.i_busy         (busy),
	.i_data_we      (i_data_we),
	.i_weight_we    (i_weight_we),
	.i_result_valid (o_result_valid),
	.i_ready        (o_ready)
);

`default_nettype wire

//--- verification/tb_conv_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "engine_macros.svh"

module tb_conv_engine;

	localparam int BL       = `ENGINE_BURST_LEN;
	localparam int N_LAYERS = 9;
	localparam int ABORT    = 7;   // Layer cut short by a reset
	localparam int POKE     = 2;   // Layer that sees a start pulse while busy
	localparam int ONES     = 6;   // Layer with every word at 16'hFFFF

	logic              clk;
	logic              rst;
	logic              i_start;
	engine_pkg::cmd_t  i_cmd;
	logic              i_data_we;
	engine_pkg::word_t i_data;
	logic              i_weight_we;
	engine_pkg::word_t i_weight;
	engine_pkg::word_t o_result;
	logic              o_result_valid;
	logic              o_ready;

	engine_pkg::word_t exp_q[$];   // Model results with the oldest first
	int n_results = 0;             // Results seen in the current layer
	int cycles    = 0;
	int limit     = 0;             // Cycle budget set before the first edge

	conv_engine u_dut (
		.clk            (clk),
		.rst            (rst),
		.i_start        (i_start),
		.i_cmd          (i_cmd),
		.i_data_we      (i_data_we),
		.i_data         (i_data),
		.i_weight_we    (i_weight_we),
		.i_weight       (i_weight),
		.o_result       (o_result),
		.o_result_valid (o_result_valid),
		.o_ready        (o_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns period
	end

	task automatic end_with_failure();
		$display("TESTS FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_result(input engine_pkg::word_t got, input engine_pkg::word_t exp,
			input string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s got %b expected %b", $time, what, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Mismatch at time %0t: %s got %0d expected %0d", $time, what, got, exp);
			end_with_failure();
		end
	endtask

	// Drive point is 1 ns past the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// Result monitor on the falling edge where outputs are settled
	always @(negedge clk) begin
		engine_pkg::word_t exp_val;
		if (!rst && o_result_valid) begin
			if (exp_q.size() == 0) begin
				$display("A result came out with no expected value left at time %0t", $time);
				end_with_failure();
			end
			exp_val = exp_q.pop_front();
			check_result(o_result, exp_val, "point result");
			n_results++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles without finishing the layers", cycles);
			end_with_failure();
		end
	end

	task automatic start_layer(input int ks, input int pts);
		engine_pkg::cmd_t cmd;
		cmd.kernel_size = `ENGINE_KSIZE_W'(ks);
		cmd.points      = `ENGINE_POINTS_W'(pts);
		n_results = 0;
		i_cmd     = cmd;
		i_start   = 1'b1;
		next_cycle();
		i_start = 1'b0;
		@(negedge clk);
		check_ready(o_ready, 1'b0, "ready after start");
		next_cycle();   // Controller is busy from here
	endtask

	// Builds the layer's words and model and then streams them
	// A negative stop_at streams the whole layer
	task automatic stream_layer(input int ks, input int pts, input bit all_ones,
			input bit poke_start, input int stop_at);
		engine_pkg::word_t      dq[$];
		engine_pkg::word_t      wq[$];
		engine_pkg::word_t      d;
		engine_pkg::word_t      w;
		engine_pkg::word_t      acc;
		engine_pkg::lane_sums_t lanes;   // Per-channel sums of the point
		logic [31:0]            full;
		int                     total;
		int                     di;
		int                     wi;
		int                     d_done;
		int                     w_done;
		int                     cyc;
		for (int p = 0; p < pts; p++) begin
			lanes = '0;
			for (int n = 0; n < ks * BL; n++) begin
				d = all_ones ? 16'hFFFF : engine_pkg::word_t'($urandom);
				w = all_ones ? 16'hFFFF : engine_pkg::word_t'($urandom);
				full = 32'(d) * 32'(w);
				lanes[n % BL] = lanes[n % BL] + full[15:0];   // Word n feeds channel n mod BL
				dq.push_back(d);
				wq.push_back(w);
			end
			acc = '0;
			for (int k = 0; k < BL; k++)
				acc = acc + lanes[k];   // Channel total wraps mod 2^16
			exp_q.push_back(acc);
		end
		total = ks * pts * BL;
		di    = 0;
		wi    = 0;
		cyc   = 0;
		while ((di < total || wi < total) && cyc != stop_at) begin
			d_done      = di;
			w_done      = wi;
			i_data_we   = 1'b0;
			i_weight_we = 1'b0;
			// A stream holds back once it is a whole atom ahead
			if (di < total && (d_done / BL) * BL <= w_done && $urandom_range(2, 0) != 0) begin
				i_data_we = 1'b1;
				i_data    = dq[di];
				di++;
			end
			if (wi < total && (w_done / BL) * BL <= d_done && $urandom_range(2, 0) != 0) begin
				i_weight_we = 1'b1;
				i_weight    = wq[wi];
				wi++;
			end
			i_start = poke_start && (cyc == 2);
			if (i_start)
				i_cmd = {`ENGINE_KSIZE_W'(ks % 9 + 1), `ENGINE_POINTS_W'(pts + 5)};
			next_cycle();
			cyc++;
		end
		i_data_we   = 1'b0;
		i_weight_we = 1'b0;
		i_start     = 1'b0;
	endtask

	task automatic run_layer(input int ks, input int pts, input bit all_ones,
			input bit poke_start);
		start_layer(ks, pts);
		stream_layer(ks, pts, all_ones, poke_start, -1);
		while (o_ready !== 1'b1)
			next_cycle();
		check_count(n_results, pts, "results in layer");
		check_count(exp_q.size(), 0, "model results left");
		repeat (2 * BL) next_cycle();
		check_ready(o_ready, 1'b1, "ready held while idle");
		check_count(n_results, pts, "results after idle");
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		exp_q.delete();   // In-flight points are lost
		repeat (8) next_cycle();
		rst = 1'b0;
		check_ready(o_ready, 1'b0, "ready after reset");
	endtask

	initial begin
		int ks_plan[N_LAYERS];
		int pts_plan[N_LAYERS];
		rst         = 1'b1;
		i_start     = 1'b0;
		i_cmd       = '0;
		i_data_we   = 1'b0;
		i_data      = '0;
		i_weight_we = 1'b0;
		i_weight    = '0;
		void'($urandom(32'h441a_7a46));
		ks_plan[0]  = 1;   // Single point with a single atom
		pts_plan[0] = 1;
		for (int l = 1; l < N_LAYERS; l++) begin
			ks_plan[l]  = $urandom_range(9, 1);
			pts_plan[l] = $urandom_range(16, 1);
		end
		limit = 300;
		for (int l = 0; l < N_LAYERS; l++)
			limit += pts_plan[l] * ks_plan[l] * 3 * BL + 40;
		repeat (8) next_cycle();
		rst = 1'b0;
		check_ready(o_ready, 1'b0, "ready after reset");
		for (int l = 0; l < N_LAYERS; l++) begin
			if (l == ABORT) begin
				start_layer(ks_plan[l], pts_plan[l]);
				stream_layer(ks_plan[l], pts_plan[l], 1'b0, 1'b0,
					(ks_plan[l] * pts_plan[l] * BL) / 2 + 1);
				apply_reset();
			end else begin
				run_layer(ks_plan[l], pts_plan[l], l == ONES, l == POKE);
			end
		end
		if (exp_q.size() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("Model results were left over at the end of the run");
			end_with_failure();
		end
	end

endmodule

`default_nettype wire
